/* controlUnit.sv */
module controlUnit (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [isaPkg::opcodeWidth-1:0] opcode,
    input  logic [isaPkg::functWidth-1:0]  funct,
    input  logic                           overflow,
    output ctrlPkg::controlWordT           ctrl
);

    isaPkg::instrClassT decodedClass;
    isaPkg::instrClassT activeClass;
    ctrlPkg::stepT step;
    ctrlPkg::excCauseT excCause;

    opcodeDecoder i_opcodeDecoder (
        .opcode       (opcode),
        .funct        (funct),
        .decodedClass (decodedClass)
    );

    stepSequencer i_stepSequencer (
        .clk          (clk),
        .reset        (reset),
        .decodedClass (decodedClass),
        .overflow     (overflow),
        .step         (step),
        .activeClass  (activeClass),
        .excCause     (excCause)
    );

    controlWordGen i_controlWordGen (
        .step        (step),
        .activeClass (activeClass),
        .excCause    (excCause),
        .ctrl        (ctrl)
    );

endmodule

/* controlUnitTb.sv */
module controlUnitTb;

    localparam int clkPeriod = 4;
    localparam int directedCount = 12;
    localparam int randomCount = 200;
    localparam int totalInstr = directedCount + randomCount;
    localparam int timeLimit = (totalInstr * 9 + 20) * clkPeriod;

    logic clk = 1'b0;
    logic reset;
    logic [isaPkg::opcodeWidth-1:0] opcode;
    logic [isaPkg::functWidth-1:0] funct;
    logic overflow;
    ctrlPkg::controlWordT ctrl;

    // Reference model state for the current cycle
    logic inReset;
    int curIdx;
    isaPkg::instrClassT curClass;
    ctrlPkg::excCauseT curCause;
    logic curOvf;
    ctrlPkg::controlWordT expWord;

    int errorCount = 0;
    int checkCount = 0;
    int passCount = 0;
    int failCount = 0;
    int testErrors = 0;
    int seed;

    controlUnit i_controlUnit (
        .clk      (clk),
        .reset    (reset),
        .opcode   (opcode),
        .funct    (funct),
        .overflow (overflow),
        .ctrl     (ctrl)
    );

    initial begin
        forever begin
            #(clkPeriod / 2) clk = ~clk;
        end
    end

    function automatic logic trapsOnOverflow(isaPkg::instrClassT cls, logic ovf);
        return ovf && (cls == isaPkg::classAdd || cls == isaPkg::classSub ||
                       cls == isaPkg::classAddi);
    endfunction

    // Cycles from one Fetch0 to the next
    function automatic int instrLength(isaPkg::instrClassT cls, logic ovf);
        int len;
        if (cls == isaPkg::classInvalid) begin
            len = 8;
        end else if (trapsOnOverflow(cls, ovf)) begin
            len = 9;
        end else begin
            len = 7;
        end
        return len;
    endfunction

    function automatic ctrlPkg::stepT stepAt(int idx, isaPkg::instrClassT cls, logic ovf);
        ctrlPkg::stepT s;
        int excStart;
        excStart = 7;
        if (cls == isaPkg::classInvalid) begin
            excStart = 5;
        end else if (trapsOnOverflow(cls, ovf)) begin
            excStart = 6;
        end
        case (idx)
            0: s = ctrlPkg::stepFetch0;
            1: s = ctrlPkg::stepFetch1;
            2: s = ctrlPkg::stepFetch2;
            3: s = ctrlPkg::stepDecode;
            4: s = ctrlPkg::stepDispatch;
            default: s = ctrlPkg::stepReset;
        endcase
        if (idx >= excStart) begin
            case (idx - excStart)
                0: s = ctrlPkg::stepExc0;
                1: s = ctrlPkg::stepExc1;
                default: s = ctrlPkg::stepExc2;
            endcase
        end else if (idx == 5) begin
            s = ctrlPkg::stepExec;
        end else if (idx == 6) begin
            s = ctrlPkg::stepWriteback;
        end
        return s;
    endfunction

    function automatic ctrlPkg::controlWordT expectedWord(int idx, isaPkg::instrClassT cls,
                                                         ctrlPkg::excCauseT cause, logic ovf);
        ctrlPkg::controlWordT w;
        w = '0;
        case (stepAt(idx, cls, ovf))
            ctrlPkg::stepFetch0: begin
                w.memRead = 1'b1;
                w.aluSrcA = ctrlPkg::srcAPc;
                w.aluSrcB = ctrlPkg::srcBFour;
                w.aluOp = ctrlPkg::aluAdd;
                w.pcWrite = 1'b1;
            end
            ctrlPkg::stepFetch1: begin
                w.memRead = 1'b1;
            end
            ctrlPkg::stepFetch2: begin
                w.memRead = 1'b1;
                w.irWrite = 1'b1;
            end
            ctrlPkg::stepDecode: begin
                w.loadAB = 1'b1;
                w.aluOutWrite = 1'b1;
                w.aluSrcA = ctrlPkg::srcAPc;
                w.aluSrcB = ctrlPkg::srcBBranch;
                w.aluOp = ctrlPkg::aluAdd;
            end
            ctrlPkg::stepExec: begin
                w.aluSrcA = ctrlPkg::srcARegA;
                w.aluOutWrite = 1'b1;
                if (cls == isaPkg::classAddi) begin
                    w.aluSrcB = ctrlPkg::srcBImm;
                end else begin
                    w.aluSrcB = ctrlPkg::srcBRegB;
                end
                case (cls)
                    isaPkg::classSub: w.aluOp = ctrlPkg::aluSub;
                    isaPkg::classAnd: w.aluOp = ctrlPkg::aluAnd;
                    default: w.aluOp = ctrlPkg::aluAdd;
                endcase
            end
            ctrlPkg::stepWriteback: begin
                w.regWrite = 1'b1;
                if (cls == isaPkg::classAddi) begin
                    w.regDst = ctrlPkg::dstRt;
                end else begin
                    w.regDst = ctrlPkg::dstRd;
                end
            end
            ctrlPkg::stepExc0: begin
                w.epcWrite = 1'b1;
                w.aluSrcA = ctrlPkg::srcAPc;
                w.aluSrcB = ctrlPkg::srcBFour;
                w.aluOp = ctrlPkg::aluSub;
                w.excCause = cause;
            end
            ctrlPkg::stepExc1: begin
                w.memRead = 1'b1;
                w.iorD = ctrlPkg::addrExcVector;
                w.excCause = cause;
            end
            ctrlPkg::stepExc2: begin
                w.pcWrite = 1'b1;
                w.pcSrc = ctrlPkg::pcExcVector;
                w.excCause = cause;
            end
            default: begin
                w = '0;
            end
        endcase
        return w;
    endfunction

    // ctrl follows the step register and settles well before the falling edge
    initial begin
        forever begin
            @(negedge clk);
            if (inReset) begin
                expWord = '0;
            end else begin
                expWord = expectedWord(curIdx, curClass, curCause, curOvf);
            end
            checkCount++;
            if (ctrl !== expWord) begin
                errorCount++;
                $display("MISMATCH ctrl at time %0t: got 0x%h expected 0x%h",
                         $time, ctrl, expWord);
            end
        end
    end

    task automatic execInstr(input logic [isaPkg::opcodeWidth-1:0] op,
                             input logic [isaPkg::functWidth-1:0] fn,
                             input isaPkg::instrClassT cls, input logic ovf);
        int len;
        ctrlPkg::excCauseT cause;
        len = instrLength(cls, ovf);
        if (cls == isaPkg::classInvalid) begin
            cause = ctrlPkg::causeInvalidOpcode;
        end else if (trapsOnOverflow(cls, ovf)) begin
            cause = ctrlPkg::causeOverflow;
        end else begin
            // Cause register keeps its last value
            cause = curCause;
        end
        for (int i = 0; i < len; i++) begin
            @(posedge clk);
            #1;
            if (i == 0) begin
                opcode = op;
                funct = fn;
            end
            inReset = 1'b0;
            curIdx = i;
            curClass = cls;
            curCause = cause;
            curOvf = ovf;
            // Overflow flag only during Exec
            overflow = ovf && (cls != isaPkg::classInvalid) && (i == 5);
        end
        @(negedge clk);
        #1;
    endtask

    task automatic randomInstr();
        logic [31:0] randWord;
        logic [isaPkg::opcodeWidth-1:0] op;
        logic [isaPkg::functWidth-1:0] fn;
        logic ovf;
        isaPkg::instrClassT cls;
        int unsigned pick;
        pick = $random(seed);
        randWord = $random(seed);
        ovf = (($random(seed) & 3) == 0);
        op = isaPkg::opRType;
        fn = randWord[5:0];
        case (pick % 5)
            0: begin
                cls = isaPkg::classAdd;
                fn = isaPkg::fnAdd;
            end
            1: begin
                cls = isaPkg::classSub;
                fn = isaPkg::fnSub;
            end
            2: begin
                cls = isaPkg::classAnd;
                fn = isaPkg::fnAnd;
            end
            3: begin
                // funct is a don't care for ADDI
                cls = isaPkg::classAddi;
                op = isaPkg::opAddi;
            end
            default: begin
                cls = isaPkg::classInvalid;
                if (randWord[31]) begin
                    op = randWord[11:6];
                    if (op == isaPkg::opRType || op == isaPkg::opAddi) begin
                        op = 6'h3f;
                    end
                end else if (fn == isaPkg::fnAdd || fn == isaPkg::fnSub ||
                             fn == isaPkg::fnAnd) begin
                    fn = 6'h3f;
                end
            end
        endcase
        execInstr(op, fn, cls, ovf);
    endtask

    task automatic startTest();
        testErrors = errorCount;
    endtask

    task automatic finishTest(input string name);
        if (errorCount == testErrors) begin
            passCount++;
            $display("test %s: ok", name);
        end else begin
            failCount++;
            $display("test %s: FAILED with %0d mismatches", name, errorCount - testErrors);
        end
    endtask

    initial begin
        seed = 8;
        reset = 1'b1;
        opcode = '0;
        funct = '0;
        overflow = 1'b0;
        inReset = 1'b1;
        curIdx = 0;
        curClass = isaPkg::classAdd;
        curCause = ctrlPkg::causeInvalidOpcode;
        curOvf = 1'b0;

        startTest();
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        #1;
        finishTest("reset");

        startTest();
        execInstr(isaPkg::opRType, isaPkg::fnAdd, isaPkg::classAdd, 1'b0);
        finishTest("add");
        startTest();
        execInstr(isaPkg::opRType, isaPkg::fnSub, isaPkg::classSub, 1'b0);
        finishTest("sub");
        startTest();
        execInstr(isaPkg::opRType, isaPkg::fnAnd, isaPkg::classAnd, 1'b0);
        finishTest("and");
        startTest();
        execInstr(isaPkg::opAddi, 6'h15, isaPkg::classAddi, 1'b0);
        finishTest("addi");

        startTest();
        execInstr(isaPkg::opRType, isaPkg::fnAdd, isaPkg::classAdd, 1'b1);
        finishTest("add overflow");
        startTest();
        execInstr(isaPkg::opRType, isaPkg::fnSub, isaPkg::classSub, 1'b1);
        finishTest("sub overflow");
        startTest();
        execInstr(isaPkg::opAddi, 6'h00, isaPkg::classAddi, 1'b1);
        finishTest("addi overflow");
        startTest();
        execInstr(isaPkg::opRType, isaPkg::fnAnd, isaPkg::classAnd, 1'b1);
        finishTest("and overflow ignored");

        startTest();
        execInstr(6'h3f, isaPkg::fnAdd, isaPkg::classInvalid, 1'b0);
        execInstr(6'h02, 6'h00, isaPkg::classInvalid, 1'b0);
        finishTest("invalid opcode");
        startTest();
        execInstr(isaPkg::opRType, 6'h00, isaPkg::classInvalid, 1'b0);
        execInstr(isaPkg::opRType, 6'h2a, isaPkg::classInvalid, 1'b0);
        finishTest("unknown funct");

        startTest();
        repeat (randomCount) begin
            randomInstr();
        end
        finishTest("random mix");

        $display("%0d passed, %0d failed, %0d cycles checked, %0d mismatches",
                 passCount, failCount, checkCount, errorCount);
        if (failCount == 0 && errorCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #(timeLimit);
        $display("ERROR: run timed out after %0d time units", timeLimit);
        $display("tests failed");
        $finish;
    end

endmodule

/* controlWordGen.sv */
module controlWordGen (
    input  ctrlPkg::stepT        step,
    input  isaPkg::instrClassT   activeClass,
    input  ctrlPkg::excCauseT    excCause,
    output ctrlPkg::controlWordT ctrl
);

    ctrlPkg::aluOpT execAluOp;
    ctrlPkg::aluSrcBT execSrcB;
    ctrlPkg::regDstT wbDst;

    // Class dependent fields for execute and write-back
    always_comb begin
        case (activeClass)
            isaPkg::classAdd,
            isaPkg::classAddi: begin
                execAluOp = ctrlPkg::aluAdd;
            end
            isaPkg::classSub: begin
                execAluOp = ctrlPkg::aluSub;
            end
            isaPkg::classAnd: begin
                execAluOp = ctrlPkg::aluAnd;
            end
            default: begin
                execAluOp = ctrlPkg::aluLoad;
            end
        endcase
    end

    assign execSrcB = (activeClass == isaPkg::classAddi) ? ctrlPkg::srcBImm
                                                         : ctrlPkg::srcBRegB;
    assign wbDst = (activeClass == isaPkg::classAddi) ? ctrlPkg::dstRt
                                                      : ctrlPkg::dstRd;

    always_comb begin
        ctrl = '0;
        case (step)
            ctrlPkg::stepFetch0: begin
                // Read instruction and bump PC by four
                ctrl.memRead = 1'b1;
                ctrl.aluSrcA = ctrlPkg::srcAPc;
                ctrl.aluSrcB = ctrlPkg::srcBFour;
                ctrl.aluOp = ctrlPkg::aluAdd;
                ctrl.pcWrite = 1'b1;
            end
            ctrlPkg::stepFetch1: begin
                ctrl.memRead = 1'b1;
            end
            ctrlPkg::stepFetch2: begin
                ctrl.memRead = 1'b1;
                ctrl.irWrite = 1'b1;
            end
            ctrlPkg::stepDecode: begin
                // Register read plus speculative branch target
                ctrl.loadAB = 1'b1;
                ctrl.aluOutWrite = 1'b1;
                ctrl.aluSrcA = ctrlPkg::srcAPc;
                ctrl.aluSrcB = ctrlPkg::srcBBranch;
                ctrl.aluOp = ctrlPkg::aluAdd;
            end
            ctrlPkg::stepExec: begin
                ctrl.aluSrcA = ctrlPkg::srcARegA;
                ctrl.aluSrcB = execSrcB;
                ctrl.aluOp = execAluOp;
                ctrl.aluOutWrite = 1'b1;
            end
            ctrlPkg::stepWriteback: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst = wbDst;
            end
            ctrlPkg::stepExc0: begin
                // EPC gets PC minus four
                ctrl.epcWrite = 1'b1;
                ctrl.aluSrcA = ctrlPkg::srcAPc;
                ctrl.aluSrcB = ctrlPkg::srcBFour;
                ctrl.aluOp = ctrlPkg::aluSub;
                ctrl.excCause = excCause;
            end
            ctrlPkg::stepExc1: begin
                ctrl.memRead = 1'b1;
                ctrl.iorD = ctrlPkg::addrExcVector;
                ctrl.excCause = excCause;
            end
            ctrlPkg::stepExc2: begin
                ctrl.pcWrite = 1'b1;
                ctrl.pcSrc = ctrlPkg::pcExcVector;
                ctrl.excCause = excCause;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

/* ctrlPkg.sv */
package ctrlPkg;

    localparam int stepWidth = 4;
    localparam int aluOpWidth = 3;
    localparam int selWidth = 2;

    // Sequencer steps, one clock each
    typedef enum logic [stepWidth-1:0] {
        stepReset = 4'd0,
        stepFetch0 = 4'd1,
        stepFetch1 = 4'd2,
        stepFetch2 = 4'd3,
        stepDecode = 4'd4,
        stepDispatch = 4'd5,
        stepExec = 4'd6,
        stepWriteback = 4'd7,
        stepExc0 = 4'd8,
        stepExc1 = 4'd9,
        stepExc2 = 4'd10
    } stepT;

    typedef enum logic [aluOpWidth-1:0] {
        aluLoad = 3'd0,
        aluAdd = 3'd1,
        aluSub = 3'd2,
        aluAnd = 3'd3
    } aluOpT;

    typedef enum logic [selWidth-1:0] {
        srcAPc = 2'd0,
        srcARegA = 2'd1
    } aluSrcAT;

    typedef enum logic [selWidth-1:0] {
        srcBRegB = 2'd0,
        srcBFour = 2'd1,
        srcBImm = 2'd2,
        srcBBranch = 2'd3
    } aluSrcBT;

    typedef enum logic [selWidth-1:0] {
        pcAluResult = 2'd0,
        pcAluOut = 2'd1,
        pcExcVector = 2'd2
    } pcSrcT;

    // Memory address source
    typedef enum logic [selWidth-1:0] {
        addrPc = 2'd0,
        addrExcVector = 2'd1
    } iorDT;

    typedef enum logic [selWidth-1:0] {
        dstRt = 2'd0,
        dstRd = 2'd1
    } regDstT;

    typedef enum logic [selWidth-1:0] {
        causeInvalidOpcode = 2'd0,
        causeOverflow = 2'd1
    } excCauseT;

    // 22 bits, all zero is the idle word
    typedef struct packed {
        aluOpT aluOp;
        aluSrcAT aluSrcA;
        aluSrcBT aluSrcB;
        pcSrcT pcSrc;
        iorDT iorD;
        regDstT regDst;
        excCauseT excCause;
        logic pcWrite;
        logic irWrite;
        logic memRead;
        logic loadAB;
        logic aluOutWrite;
        logic regWrite;
        logic epcWrite;
    } controlWordT;

endpackage

/* flist.f */
isaPkg.sv
ctrlPkg.sv
opcodeDecoder.sv
stepSequencer.sv
controlWordGen.sv
controlUnit.sv
controlUnitTb.sv

/* isaPkg.sv */
package isaPkg;

    localparam int opcodeWidth = 6;
    localparam int functWidth = 6;
    localparam int classWidth = 3;

    // Primary opcodes still supported
    localparam logic [opcodeWidth-1:0] opRType = 6'h00;
    localparam logic [opcodeWidth-1:0] opAddi = 6'h08;

    // Funct codes under opRType
    localparam logic [functWidth-1:0] fnAdd = 6'h20;
    localparam logic [functWidth-1:0] fnSub = 6'h22;
    localparam logic [functWidth-1:0] fnAnd = 6'h24;

    // Instruction class after decode
    typedef enum logic [classWidth-1:0] {
        classAdd = 3'd0,
        classSub = 3'd1,
        classAnd = 3'd2,
        classAddi = 3'd3,
        classInvalid = 3'd4
    } instrClassT;

endpackage

/* opcodeDecoder.sv */
module opcodeDecoder (
    input  logic [isaPkg::opcodeWidth-1:0] opcode,
    input  logic [isaPkg::functWidth-1:0]  funct,
    output isaPkg::instrClassT              decodedClass
);

    always_comb begin
        decodedClass = isaPkg::classInvalid;
        case (opcode)
            isaPkg::opRType: begin
                // R format is resolved by funct
                case (funct)
                    isaPkg::fnAdd: begin
                        decodedClass = isaPkg::classAdd;
                    end
                    isaPkg::fnSub: begin
                        decodedClass = isaPkg::classSub;
                    end
                    isaPkg::fnAnd: begin
                        decodedClass = isaPkg::classAnd;
                    end
                    default: begin
                        decodedClass = isaPkg::classInvalid;
                    end
                endcase
            end
            isaPkg::opAddi: begin
                decodedClass = isaPkg::classAddi;
            end
            default: begin
                decodedClass = isaPkg::classInvalid;
            end
        endcase
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f flist.f --top-module controlUnitTb -o controlUnitSim
output="$(./obj_dir/controlUnitSim)"
echo "$output"

if grep -qx "all tests passed" <<< "$output"; then
    exit 0
fi
exit 1

/* stepSequencer.sv */
module stepSequencer (
    input  logic               clk,
    input  logic               reset,
    input  isaPkg::instrClassT decodedClass,
    input  logic               overflow,
    output ctrlPkg::stepT      step,
    output isaPkg::instrClassT activeClass,
    output ctrlPkg::excCauseT  excCause
);

    ctrlPkg::stepT nextStep;
    ctrlPkg::excCauseT nextCause;
    isaPkg::instrClassT nextClass;
    logic arithClass;

    // Only these classes can trap on overflow
    assign arithClass = (activeClass == isaPkg::classAdd) ||
                        (activeClass == isaPkg::classSub) ||
                        (activeClass == isaPkg::classAddi);

    always_comb begin
        nextStep = step;
        nextCause = excCause;
        nextClass = activeClass;
        case (step)
            ctrlPkg::stepReset: begin
                nextStep = ctrlPkg::stepFetch0;
            end
            ctrlPkg::stepFetch0: begin
                nextStep = ctrlPkg::stepFetch1;
            end
            ctrlPkg::stepFetch1: begin
                nextStep = ctrlPkg::stepFetch2;
            end
            ctrlPkg::stepFetch2: begin
                nextStep = ctrlPkg::stepDecode;
            end
            ctrlPkg::stepDecode: begin
                nextStep = ctrlPkg::stepDispatch;
            end
            ctrlPkg::stepDispatch: begin
                nextClass = decodedClass;
                if (decodedClass == isaPkg::classInvalid) begin
                    nextStep = ctrlPkg::stepExc0;
                    nextCause = ctrlPkg::causeInvalidOpcode;
                end else begin
                    nextStep = ctrlPkg::stepExec;
                end
            end
            ctrlPkg::stepExec: begin
                if (overflow && arithClass) begin
                    nextStep = ctrlPkg::stepExc0;
                    nextCause = ctrlPkg::causeOverflow;
                end else begin
                    nextStep = ctrlPkg::stepWriteback;
                end
            end
            ctrlPkg::stepExc0: begin
                nextStep = ctrlPkg::stepExc1;
            end
            ctrlPkg::stepExc1: begin
                nextStep = ctrlPkg::stepExc2;
            end
            ctrlPkg::stepWriteback,
            ctrlPkg::stepExc2: begin
                nextStep = ctrlPkg::stepFetch0;
            end
            default: begin
                nextStep = ctrlPkg::stepReset;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            step <= ctrlPkg::stepReset;
            activeClass <= isaPkg::classAdd;
            excCause <= ctrlPkg::causeInvalidOpcode;
        end else begin
            step <= nextStep;
            activeClass <= nextClass;
            excCause <= nextCause;
        end
    end

endmodule
